//--- Makefile
TOP = tb_top
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir $(OBJ) -o sim_$(TOP)

run: compile
	./$(OBJ)/sim_$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- flist.f
+incdir+rtl
rtl/hub_pkg.sv
rtl/reg_mem.sv
rtl/mem_sched.sv
rtl/spi_master.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/periph_hub.sv
tests/hub_asserts.sv
tests/tb_clock.sv
tests/tb_top.sv

//--- rtl/hub_macros.svh
`ifndef HUB_MACROS_SVH
`define HUB_MACROS_SVH

`define HUB_ADDR_W	5
`define HUB_DATA_W	32
`define TAG_W		4

// Words the host writes
`define A_SPI_TXD	5'd0
`define A_SPI_CTL	5'd1
`define A_UART_TXD	5'd2
`define A_UART_CTL	5'd3

// Words the scheduler writes
`define A_SPI_STAT	5'd16
`define A_SPI_RXD	5'd17
`define A_UART_STAT	5'd18
`define A_UART_RXD	5'd19
`define SCHED_OWN_BIT	4	// Set in every scheduler-owned address

`define SPI_CTL_TAG	3:0
`define SPI_CTL_SEL	5:4
`define SPI_CTL_LEN	12:8	// Bit count minus one
`define SPI_CTL_DIV	23:16	// Half-period minus one
`define UART_CTL_TAG	3:0
`define UART_CTL_DIV	31:16	// Clocks per bit

`define SPI_STAT_TAG	3:0
`define SPI_STAT_BUSY	4
`define UART_STAT_TAG	3:0
`define UART_STAT_BUSY	4
`define UART_STAT_RXCNT	15:8

`endif

//--- rtl/hub_pkg.sv
`include "hub_macros.svh"

package hub_pkg;

	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_SHIFT,
		SPI_DONE	// Last high half-period before the select is released
	} spi_state_t;

	typedef enum logic [1:0] {
		U_IDLE,
		U_START,
		U_DATA,
		U_STOP
	} uart_state_t;

	typedef enum logic [2:0] {
		SL_SPI_TXD,
		SL_SPI_CTL,
		SL_SPI_STAT,
		SL_SPI_RXD,
		SL_UART_TXD,
		SL_UART_CTL,
		SL_UART_STAT,
		SL_UART_RXD
	} sched_slot_t;

	typedef struct packed {
		logic [`HUB_DATA_W-1:0] data;	// Sent from bit 31 down
		logic [4:0]             len;
		logic [1:0]             sel;
		logic [7:0]             div;	// Each sck half lasts div+1 clocks
	} spi_cmd_t;

	typedef struct packed {
		logic [7:0]  data;
		logic [15:0] div;
	} uart_tx_cmd_t;

	typedef struct packed {
		logic                   busy;
		logic [`HUB_DATA_W-1:0] rxd;	// Right-justified
	} spi_stat_t;

endpackage

//--- rtl/mem_sched.sv
`timescale 1ns/1ps
`include "hub_macros.svh"

module mem_sched import hub_pkg::*; (
	input  logic                   clk,
	input  logic                   nrst,
	output logic [`HUB_ADDR_W-1:0] o_addr,
	output logic                   o_we,
	output logic [`HUB_DATA_W-1:0] o_wdata,
	input  logic [`HUB_DATA_W-1:0] i_rdata,
	output spi_cmd_t               o_spi_cmd,
	output logic                   o_spi_valid,
	input  logic                   i_spi_ready,
	input  spi_stat_t              i_spi_stat,
	output uart_tx_cmd_t           o_utx_cmd,
	output logic                   o_utx_valid,
	input  logic                   i_utx_ready,
	input  logic                   i_utx_busy,
	output logic [15:0]            o_urx_div,
	input  logic [7:0]             i_urx_byte,
	input  logic                   i_urx_valid
);
	sched_slot_t            slot;
	logic [`HUB_DATA_W-1:0] spi_txd;
	logic [7:0]             utx_txd;
	logic [`TAG_W-1:0]      spi_pend, spi_last, spi_done;
	logic [`TAG_W-1:0]      utx_pend, utx_last, utx_done;
	logic                   spi_busy_q, utx_busy_q;
	logic                   spi_start, utx_start;
	logic [7:0]             rx_byte, rx_cnt;
	logic [`HUB_DATA_W-1:0] spi_stat_w, uart_stat_w;

	// Read data of the CTL word arrives in the STAT slot
	assign spi_start = (slot == SL_SPI_STAT) && !o_spi_valid &&
		(i_rdata[`SPI_CTL_TAG] != spi_last);
	assign utx_start = (slot == SL_UART_STAT) && !o_utx_valid &&
		(i_rdata[`UART_CTL_TAG] != utx_last);

	always_comb begin
		spi_stat_w                   = '0;
		spi_stat_w[`SPI_STAT_TAG]    = spi_done;
		spi_stat_w[`SPI_STAT_BUSY]   = i_spi_stat.busy;
		uart_stat_w                  = '0;
		uart_stat_w[`UART_STAT_TAG]  = utx_done;
		uart_stat_w[`UART_STAT_BUSY] = i_utx_busy;
		uart_stat_w[`UART_STAT_RXCNT] = rx_cnt;
	end

	always_comb begin
		o_addr  = `A_SPI_TXD;
		o_we    = 1'b0;
		o_wdata = '0;
		case (slot)
			SL_SPI_TXD:   o_addr = `A_SPI_TXD;
			SL_SPI_CTL:   o_addr = `A_SPI_CTL;
			SL_SPI_STAT: begin
				o_addr  = `A_SPI_STAT;
				o_we    = 1'b1;
				o_wdata = spi_stat_w;
			end
			SL_SPI_RXD: begin
				o_addr  = `A_SPI_RXD;
				o_we    = 1'b1;
				o_wdata = i_spi_stat.rxd;
			end
			SL_UART_TXD:  o_addr = `A_UART_TXD;
			SL_UART_CTL:  o_addr = `A_UART_CTL;
			SL_UART_STAT: begin
				o_addr  = `A_UART_STAT;
				o_we    = 1'b1;
				o_wdata = uart_stat_w;
			end
			SL_UART_RXD: begin
				o_addr  = `A_UART_RXD;
				o_we    = 1'b1;
				o_wdata = {24'd0, rx_byte};
			end
			default: o_addr = `A_SPI_TXD;
		endcase
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			slot        <= SL_SPI_TXD;
			o_spi_valid <= 1'b0;
			o_utx_valid <= 1'b0;
			spi_pend    <= '0;
			spi_last    <= '0;
			spi_done    <= '0;
			utx_pend    <= '0;
			utx_last    <= '0;
			utx_done    <= '0;
			spi_busy_q  <= 1'b0;
			utx_busy_q  <= 1'b0;
			o_urx_div   <= '0;
			rx_byte     <= '0;
			rx_cnt      <= '0;
		end else begin
			slot       <= sched_slot_t'(slot + 3'd1);	// Wraps after the UART RXD slot
			spi_busy_q <= i_spi_stat.busy;
			utx_busy_q <= i_utx_busy;
			if (o_spi_valid && i_spi_ready) begin
				o_spi_valid <= 1'b0;
				spi_last    <= spi_pend;
			end
			if (spi_start) begin
				o_spi_valid <= 1'b1;
				spi_pend    <= i_rdata[`SPI_CTL_TAG];
			end
			if (spi_busy_q && !i_spi_stat.busy)
				spi_done <= spi_last;	// Transfer just finished
			if (o_utx_valid && i_utx_ready) begin
				o_utx_valid <= 1'b0;
				utx_last    <= utx_pend;
			end
			if (utx_start) begin
				o_utx_valid <= 1'b1;
				utx_pend    <= i_rdata[`UART_CTL_TAG];
			end
			if (utx_busy_q && !i_utx_busy)
				utx_done <= utx_last;
			if (slot == SL_UART_STAT)
				o_urx_div <= i_rdata[`UART_CTL_DIV];	// Receiver follows every CTL read
			if (i_urx_valid) begin
				rx_byte <= i_urx_byte;
				rx_cnt  <= rx_cnt + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (slot == SL_SPI_CTL)
			spi_txd <= i_rdata;
		if (slot == SL_UART_CTL)
			utx_txd <= i_rdata[7:0];
		if (spi_start)
			o_spi_cmd <= '{data: spi_txd, len: i_rdata[`SPI_CTL_LEN],
				sel: i_rdata[`SPI_CTL_SEL], div: i_rdata[`SPI_CTL_DIV]};
		if (utx_start)
			o_utx_cmd <= '{data: utx_txd, div: i_rdata[`UART_CTL_DIV]};
	end

endmodule

//--- rtl/periph_hub.sv
`timescale 1ns/1ps
`include "hub_macros.svh"

module periph_hub import hub_pkg::*; (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   i_host_valid,
	input  logic                   i_host_we,
	input  logic [`HUB_ADDR_W-1:0] i_host_addr,
	input  logic [`HUB_DATA_W-1:0] i_host_wdata,
	output logic                   o_host_ready,
	output logic [`HUB_DATA_W-1:0] o_host_rdata,
	output logic                   o_host_rvalid,
	output logic                   o_spi_sck,
	output logic                   o_spi_mosi,
	input  logic                   i_spi_miso,
	output logic [3:0]             o_spi_ss_n,
	output logic                   o_uart_tx,
	input  logic                   i_uart_rx
);
	logic [`HUB_ADDR_W-1:0] s_addr;
	logic                   s_we;
	logic [`HUB_DATA_W-1:0] s_wdata;
	logic [`HUB_DATA_W-1:0] s_rdata;
	spi_cmd_t               spi_cmd;
	logic                   spi_valid, spi_ready;
	spi_stat_t              spi_stat;
	uart_tx_cmd_t           utx_cmd;
	logic                   utx_valid, utx_ready, utx_busy;
	logic [15:0]            urx_div;
	logic [7:0]             urx_byte;
	logic                   urx_valid;

	reg_mem u_mem (
		.clk        (clk),
		.nrst       (nrst),
		.i_h_valid  (i_host_valid),
		.i_h_we     (i_host_we),
		.i_h_addr   (i_host_addr),
		.i_h_wdata  (i_host_wdata),
		.o_h_ready  (o_host_ready),
		.o_h_rdata  (o_host_rdata),
		.o_h_rvalid (o_host_rvalid),
		.i_s_addr   (s_addr),
		.i_s_we     (s_we),
		.i_s_wdata  (s_wdata),
		.o_s_rdata  (s_rdata)
	);

	mem_sched u_sched (
		.clk         (clk),
		.nrst        (nrst),
		.o_addr      (s_addr),
		.o_we        (s_we),
		.o_wdata     (s_wdata),
		.i_rdata     (s_rdata),
		.o_spi_cmd   (spi_cmd),
		.o_spi_valid (spi_valid),
		.i_spi_ready (spi_ready),
		.i_spi_stat  (spi_stat),
		.o_utx_cmd   (utx_cmd),
		.o_utx_valid (utx_valid),
		.i_utx_ready (utx_ready),
		.i_utx_busy  (utx_busy),
		.o_urx_div   (urx_div),
		.i_urx_byte  (urx_byte),
		.i_urx_valid (urx_valid)
	);

	spi_master u_spi (
		.clk     (clk),
		.nrst    (nrst),
		.i_cmd   (spi_cmd),
		.i_valid (spi_valid),
		.o_ready (spi_ready),
		.o_stat  (spi_stat),
		.o_sck   (o_spi_sck),
		.o_mosi  (o_spi_mosi),
		.i_miso  (i_spi_miso),
		.o_ss_n  (o_spi_ss_n)
	);

	uart_tx u_utx (
		.clk     (clk),
		.nrst    (nrst),
		.i_cmd   (utx_cmd),
		.i_valid (utx_valid),
		.o_ready (utx_ready),
		.o_busy  (utx_busy),
		.o_tx    (o_uart_tx)
	);

	uart_rx u_urx (
		.clk     (clk),
		.nrst    (nrst),
		.i_div   (urx_div),
		.i_rx    (i_uart_rx),
		.o_byte  (urx_byte),
		.o_valid (urx_valid)
	);

endmodule

//--- rtl/reg_mem.sv
`timescale 1ns/1ps
`include "hub_macros.svh"

module reg_mem (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   i_h_valid,
	input  logic                   i_h_we,
	input  logic [`HUB_ADDR_W-1:0] i_h_addr,
	input  logic [`HUB_DATA_W-1:0] i_h_wdata,
	output logic                   o_h_ready,
	output logic [`HUB_DATA_W-1:0] o_h_rdata,
	output logic                   o_h_rvalid,
	input  logic [`HUB_ADDR_W-1:0] i_s_addr,
	input  logic                   i_s_we,
	input  logic [`HUB_DATA_W-1:0] i_s_wdata,
	output logic [`HUB_DATA_W-1:0] o_s_rdata
);
	logic [`HUB_DATA_W-1:0] mem [2**`HUB_ADDR_W];
	logic                   h_acc;

	assign o_h_ready = !(i_s_we && (i_s_addr == i_h_addr));	// Scheduler wins a clash
	assign h_acc     = i_h_valid && o_h_ready;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			for (int i = 0; i < 2**`HUB_ADDR_W; i++)
				mem[i] <= '0;
			o_h_rvalid <= 1'b0;
		end else begin
			if (i_s_we)
				mem[i_s_addr] <= i_s_wdata;
			if (h_acc && i_h_we && !i_h_addr[`SCHED_OWN_BIT])
				mem[i_h_addr] <= i_h_wdata;	// Status half is read-only to the host
			o_h_rvalid <= h_acc && !i_h_we;
		end
	end

	// Both read ports return data one cycle after the address
	always_ff @(posedge clk) begin
		o_s_rdata <= mem[i_s_addr];
		if (h_acc && !i_h_we)
			o_h_rdata <= mem[i_h_addr];
	end

endmodule

//--- rtl/spi_master.sv
`timescale 1ns/1ps

module spi_master import hub_pkg::*; (
	input  logic       clk,
	input  logic       nrst,
	input  spi_cmd_t   i_cmd,
	input  logic       i_valid,
	output logic       o_ready,
	output spi_stat_t  o_stat,
	output logic       o_sck,
	output logic       o_mosi,
	input  logic       i_miso,
	output logic [3:0] o_ss_n
);
	spi_state_t  state;
	logic [31:0] tx_sr;
	logic [31:0] rx_sr;
	logic [4:0]  bits_left;
	logic [7:0]  div;
	logic [7:0]  div_cnt;
	logic        half_end;

	assign o_ready     = (state == SPI_IDLE);
	assign o_stat.busy = (state != SPI_IDLE);
	assign o_stat.rxd  = rx_sr;
	assign o_mosi      = tx_sr[31];
	assign half_end    = (div_cnt == div);

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state     <= SPI_IDLE;
			o_sck     <= 1'b0;
			o_ss_n    <= '1;
			tx_sr     <= '0;
			rx_sr     <= '0;
			bits_left <= '0;
			div       <= '0;
			div_cnt   <= '0;
		end else begin
			div_cnt <= (state == SPI_IDLE || half_end) ? 8'd0 : div_cnt + 8'd1;
			case (state)
				SPI_IDLE: if (i_valid) begin
					state     <= SPI_SHIFT;
					o_ss_n    <= ~(4'b0001 << i_cmd.sel);
					tx_sr     <= i_cmd.data;
					rx_sr     <= '0;
					bits_left <= i_cmd.len;
					div       <= i_cmd.div;
				end
				SPI_SHIFT: if (half_end) begin
					o_sck <= ~o_sck;
					if (!o_sck) begin
						rx_sr <= {rx_sr[30:0], i_miso};	// Sample on rising sck
						if (bits_left == 5'd0)
							state <= SPI_DONE;
					end else begin
						tx_sr     <= tx_sr << 1;	// Next bit on falling sck
						bits_left <= bits_left - 5'd1;
					end
				end
				SPI_DONE: if (half_end) begin
					o_sck  <= 1'b0;
					o_ss_n <= '1;
					state  <= SPI_IDLE;
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import hub_pkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  logic [15:0] i_div,
	input  logic        i_rx,
	output logic [7:0]  o_byte,
	output logic        o_valid
);
	uart_state_t state;
	logic        rx_s1, rx_s2;
	logic [15:0] cnt;
	logic [2:0]  bit_idx;
	logic [7:0]  sh;
	logic        bit_end;

	assign bit_end = (cnt == i_div - 16'd1);

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			rx_s1   <= 1'b1;
			rx_s2   <= 1'b1;
			state   <= U_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			o_valid <= 1'b0;
		end else begin
			rx_s1   <= i_rx;	// Two-flop synchronizer
			rx_s2   <= rx_s1;
			o_valid <= 1'b0;
			case (state)
				U_IDLE: begin
					cnt <= 16'd1;	// Edge cycle counts as the first start-bit clock
					if (!rx_s2)
						state <= U_START;
				end
				U_START: if (cnt >= (i_div >> 1)) begin
					cnt     <= '0;
					bit_idx <= '0;
					state   <= rx_s2 ? U_IDLE : U_DATA;	// Glitch returns to idle
				end else
					cnt <= cnt + 16'd1;
				U_DATA: if (bit_end) begin
					cnt     <= '0;
					bit_idx <= bit_idx + 3'd1;
					if (bit_idx == 3'd7)
						state <= U_STOP;
				end else
					cnt <= cnt + 16'd1;
				U_STOP: if (bit_end) begin
					state   <= U_IDLE;
					o_valid <= rx_s2;	// Bad stop bit drops the frame
				end else
					cnt <= cnt + 16'd1;
				default: state <= U_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == U_DATA && bit_end)
			sh <= {rx_s2, sh[7:1]};
		if (state == U_STOP && bit_end)
			o_byte <= sh;
	end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import hub_pkg::*; (
	input  logic         clk,
	input  logic         nrst,
	input  uart_tx_cmd_t i_cmd,
	input  logic         i_valid,
	output logic         o_ready,
	output logic         o_busy,
	output logic         o_tx
);
	uart_state_t state;
	logic [7:0]  sh;
	logic [15:0] div;
	logic [15:0] cnt;
	logic [2:0]  bit_idx;
	logic        bit_end;

	assign o_ready = (state == U_IDLE);
	assign o_busy  = !o_ready;
	assign bit_end = (cnt == div - 16'd1);

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state   <= U_IDLE;
			o_tx    <= 1'b1;	// Line idles high
			cnt     <= '0;
			bit_idx <= '0;
		end else begin
			cnt <= (state == U_IDLE || bit_end) ? 16'd0 : cnt + 16'd1;
			case (state)
				U_IDLE: if (i_valid) begin
					state <= U_START;
					o_tx  <= 1'b0;
				end
				U_START: if (bit_end) begin
					state   <= U_DATA;
					o_tx    <= sh[0];
					bit_idx <= 3'd0;
				end
				U_DATA: if (bit_end) begin
					if (bit_idx == 3'd7) begin
						state <= U_STOP;
						o_tx  <= 1'b1;
					end else begin
						o_tx    <= sh[bit_idx + 3'd1];	// LSB first
						bit_idx <= bit_idx + 3'd1;
					end
				end
				U_STOP: if (bit_end)
					state <= U_IDLE;
				default: state <= U_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (o_ready && i_valid) begin
			sh  <= i_cmd.data;
			div <= i_cmd.div;
		end
	end

endmodule

//--- tests/hub_asserts.sv
`timescale 1ns/1ps

module hub_asserts (
	input logic       clk,
	input logic       nrst,
	input logic       i_host_valid,
	input logic       i_host_we,
	input logic       i_host_ready,
	input logic       i_host_rvalid,
	input logic       i_spi_sck,
	input logic [3:0] i_spi_ss_n
);
	logic host_rd_acc;
	int   fails = 0;	// Failed assertion count, read by the testbench

	assign host_rd_acc = i_host_valid && i_host_ready && !i_host_we;

	ss_onehot: assert property (@(posedge clk) disable iff (!nrst)
		$onehot0(~i_spi_ss_n))
		else begin
			$error("More than one SPI select is low");
			fails++;
		end

	// Mode 0 keeps sck low between transfers
	sck_idle: assert property (@(posedge clk) disable iff (!nrst)
		(&i_spi_ss_n) |-> !i_spi_sck)
		else begin
			$error("SPI clock high with no slave selected");
			fails++;
		end

	rvalid_delay: assert property (@(posedge clk) disable iff (!nrst)
		i_host_rvalid == $past(host_rd_acc))
		else begin
			$error("Host read valid not exactly one cycle after the accepted read");
			fails++;
		end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD_NS = 4.0
) (
	output logic o_clk
);
	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
	end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/1ps
`include "hub_macros.svh"

module tb_top;
	localparam int N_SPI     = 12;
	localparam int N_UART    = 6;
	localparam int N_XFER    = N_SPI + N_UART + 2;	// Two rewrites with an old tag
	localparam int WORST_CYC = 32 * 2 * 4 + 40;	// 32 bits at divider 3, plus polling
	localparam int TIMEOUT_CYC = N_XFER * WORST_CYC * 3;
	localparam int MAX_UART_DIV = 23;
	localparam int QUIET_CYC = 16 + 10 * MAX_UART_DIV + 16;	// Start, longest frame, status

	logic                   clk;
	logic                   nrst;
	logic                   host_valid;
	logic                   host_we;
	logic [`HUB_ADDR_W-1:0] host_addr;
	logic [`HUB_DATA_W-1:0] host_wdata;
	logic                   host_ready;
	logic [`HUB_DATA_W-1:0] host_rdata;
	logic                   host_rvalid;
	logic                   spi_sck;
	logic                   spi_mosi;
	logic                   spi_miso;
	logic [3:0]             spi_ss_n;
	logic                   uart_line;	// TX looped back to RX

	logic [31:0] seed = 32'd51;
	int          errors = 0;
	int          checks = 0;
	logic [3:0]  spi_tag = 4'd0;
	logic [3:0]  uart_tag = 4'd0;
	logic [31:0] spi_ctl_last = 32'd0;
	logic [31:0] uart_ctl_last = 32'd0;
	logic [7:0]  rx_count = 8'd0;	// Bytes the receiver should have counted
	logic [7:0]  uart_byte_last = 8'd0;

	// SPI slave model state
	logic        sck_q = 1'b0;
	logic [3:0]  ss_q = 4'hf;
	logic [31:0] slave_rand;
	logic [31:0] mosi_word = 32'd0;
	logic [31:0] miso_word = 32'd0;
	int          sck_rises = 0;
	logic [3:0]  ss_seen = 4'hf;
	logic        ss_stable = 1'b1;

	tb_clock #(.PERIOD_NS(4.0)) u_clk (.o_clk(clk));

	periph_hub uut (
		.clk           (clk),
		.nrst          (nrst),
		.i_host_valid  (host_valid),
		.i_host_we     (host_we),
		.i_host_addr   (host_addr),
		.i_host_wdata  (host_wdata),
		.o_host_ready  (host_ready),
		.o_host_rdata  (host_rdata),
		.o_host_rvalid (host_rvalid),
		.o_spi_sck     (spi_sck),
		.o_spi_mosi    (spi_mosi),
		.i_spi_miso    (spi_miso),
		.o_spi_ss_n    (spi_ss_n),
		.o_uart_tx     (uart_line),
		.i_uart_rx     (uart_line)
	);

	bind periph_hub hub_asserts u_asserts (
		.clk           (clk),
		.nrst          (nrst),
		.i_host_valid  (i_host_valid),
		.i_host_we     (i_host_we),
		.i_host_ready  (o_host_ready),
		.i_host_rvalid (o_host_rvalid),
		.i_spi_sck     (o_spi_sck),
		.i_spi_ss_n    (o_spi_ss_n)
	);

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Status half contents once every transfer has finished
	function automatic logic [31:0] expected_word(input logic [4:0] addr);
		case (addr)
			`A_SPI_STAT:  return {28'd0, spi_tag};
			`A_SPI_RXD:   return miso_word;
			`A_UART_STAT: return {16'd0, rx_count, 4'd0, uart_tag};
			`A_UART_RXD:  return {24'd0, uart_byte_last};
			default:      return 32'd0;
		endcase
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic host_write(input logic [4:0] addr, input logic [31:0] data);
		logic done;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			host_valid = 1'b1;
			host_we    = 1'b1;
			host_addr  = addr;
			host_wdata = data;
			#1;
			done = host_ready;	// Stalls while the scheduler writes the same word
			@(posedge clk);
		end
		@(negedge clk);
		host_valid = 1'b0;
		host_we    = 1'b0;
	endtask

	task automatic host_read(input logic [4:0] addr, output logic [31:0] data);
		logic done;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			host_valid = 1'b1;
			host_we    = 1'b0;
			host_addr  = addr;
			#1;
			done = host_ready;
			@(posedge clk);
		end
		@(negedge clk);
		host_valid = 1'b0;
		checks++;
		assert (host_rvalid) else begin
			errors++;
			$display("Read of word %0d got no read-valid one cycle after it was accepted", addr);
		end
		data = host_rdata;
	endtask

	// Polls a status word until the done tag and, if asked, the rx count match
	task automatic wait_status(input logic [4:0] addr, input logic [3:0] tag,
		input logic use_cnt, input logic [7:0] cnt, output logic [31:0] stat);
		do
			host_read(addr, stat);
		while (stat[3:0] != tag || (use_cnt && stat[15:8] != cnt));
	endtask

	task automatic watch_quiet(input int cycles);
		logic active;
		active = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			if (!(&spi_ss_n) || !uart_line)
				active = 1'b1;
		end
		check_eq({31'd0, active}, 32'd0, "pin activity after a rewrite with an old tag");
	endtask

	task automatic run_spi();
		logic [31:0] r;
		logic [31:0] data;
		logic [31:0] ctl;
		logic [31:0] stat;
		logic [31:0] rxd;
		logic [4:0]  len;
		logic [1:0]  sel;
		logic [7:0]  div;
		data    = next_rand();
		r       = next_rand();
		len     = r[20:16];
		sel     = r[25:24];
		div     = 8'(32'd1 + {30'd0, r[29:28]} % 32'd3);
		spi_tag = spi_tag + 4'd1;
		ctl     = {8'd0, div, 3'd0, len, 2'd0, sel, spi_tag};
		host_write(`A_SPI_TXD, data);
		host_write(`A_SPI_CTL, ctl);
		wait_status(`A_SPI_STAT, spi_tag, 1'b0, 8'd0, stat);
		check_eq({31'd0, stat[4]}, 32'd0, "SPI busy after done");
		host_read(`A_SPI_RXD, rxd);
		check_eq(32'(sck_rises), {27'd0, len} + 32'd1, "SPI rising sck count");
		check_eq(mosi_word, data >> (5'd31 - len), "SPI MOSI bits");
		check_eq({28'd0, ss_seen}, {28'd0, ~(4'b0001 << sel)}, "SPI selects");
		check_eq({31'd0, ss_stable}, 32'd1, "SPI select held through transfer");
		check_eq(rxd, miso_word, "SPI_RXD");
		spi_ctl_last = ctl;
	endtask

	task automatic run_uart();
		logic [31:0] r;
		logic [31:0] ctl;
		logic [31:0] stat;
		logic [31:0] rxd;
		logic [7:0]  byte_v;
		logic [15:0] div;
		r      = next_rand();
		byte_v = r[23:16];
		div    = 16'(32'd8 + {28'd0, r[27:24]});	// Enough clocks for mid-bit sampling
		uart_tag = uart_tag + 4'd1;
		ctl      = {div, 12'd0, uart_tag};
		host_write(`A_UART_TXD, {24'd0, byte_v});
		host_write(`A_UART_CTL, ctl);
		wait_status(`A_UART_STAT, uart_tag, 1'b1, rx_count + 8'd1, stat);
		rx_count = rx_count + 8'd1;
		check_eq({31'd0, stat[4]}, 32'd0, "UART TX busy after done");
		host_read(`A_UART_RXD, rxd);
		check_eq(rxd, {24'd0, byte_v}, "UART_RXD");
		uart_ctl_last  = ctl;
		uart_byte_last = byte_v;
	endtask

	// Mode 0 slave, new MISO bit after each falling sck, both lines seen on rising sck
	always @(negedge clk) begin
		if (&ss_q && !(&spi_ss_n)) begin
			slave_rand = next_rand();
			spi_miso   = slave_rand[24];
			mosi_word  = 32'd0;
			miso_word  = 32'd0;
			sck_rises  = 0;
			ss_seen    = spi_ss_n;
			ss_stable  = 1'b1;
		end else if (sck_q && !spi_sck && !(&spi_ss_n)) begin
			slave_rand = next_rand();
			spi_miso   = slave_rand[24];
		end
		if (!sck_q && spi_sck) begin
			mosi_word = {mosi_word[30:0], spi_mosi};
			miso_word = {miso_word[30:0], spi_miso};
			sck_rises++;
			if (spi_ss_n != ss_seen)
				ss_stable = 1'b0;
		end
		sck_q = spi_sck;
		ss_q  = spi_ss_n;
	end

	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk);
		$display("Watchdog expired after %0d cycles, a transfer or the host port hung",
			TIMEOUT_CYC);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		nrst       = 1'b0;
		host_valid = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		spi_miso   = 1'b0;
		repeat (16) @(negedge clk);
		nrst = 1'b1;

		for (int a = 0; a < 32; a++) begin
			host_read(5'(a), rd);
			check_eq(rd, 32'd0, $sformatf("word %0d after reset", a));
		end
		check_eq({31'd0, spi_sck}, 32'd0, "sck after reset");
		check_eq({28'd0, spi_ss_n}, 32'hf, "selects after reset");
		check_eq({31'd0, uart_line}, 32'd1, "UART TX after reset");

		for (int i = 0; i < N_SPI; i++)
			run_spi();
		for (int i = 0; i < N_UART; i++)
			run_uart();

		// Same tags again, nothing may start
		host_write(`A_SPI_TXD, next_rand());
		host_write(`A_SPI_CTL, spi_ctl_last);
		host_write(`A_UART_CTL, uart_ctl_last);
		watch_quiet(QUIET_CYC);
		host_read(`A_UART_STAT, rd);
		check_eq({24'd0, rd[15:8]}, {24'd0, rx_count}, "rx count after old-tag rewrite");

		for (int a = 16; a < 32; a++)
			host_write(5'(a), next_rand());
		for (int a = 16; a < 32; a++) begin
			host_read(5'(a), rd);
			check_eq(rd, expected_word(5'(a)),
				$sformatf("status word %0d after host write", a));
		end

		$display("Checks run: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, uut.u_asserts.fails);
		if (errors == 0 && uut.u_asserts.fails == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
